/* build.f */
+incdir+.
memAccessPkg.sv
memCtrlPkg.sv
reqCapture.sv
memSequencer.sv
byteRam.sv
memTop.sv
memTop_chk.sv
tbClock.sv
memScoreboard.sv
memTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# the log decides the result, a missing closing line counts as failure
run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* memTb.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module memTb
    import memAccessPkg::*;
;
    localparam int     ackTimeout = 200;
    localparam integer baseSeed = 32'h4c339dfe;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    logic                   stallOn;
    logic                   fetchReq;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic                   fetchAck;
    logic [`MEM_WORD_W-1:0] fetchWord;
    logic                   dataReq;
    logic [`MEM_ADDR_W-1:0] dataAddr;
    accessKindT             dataKind;
    accessLenT              dataLen;
    logic [`MEM_WORD_W-1:0] dataWdata;
    logic                   dataAck;
    logic [`MEM_WORD_W-1:0] dataRword;
    int                     checks;
    int                     errors;
    int                     failsSeen = 0;
    logic                   timedOut = 1'b0;
    integer                 dataSeed = baseSeed;
    integer                 fetchSeed = baseSeed + 1;
    integer                 stallSeed = baseSeed + 2;

    tbClock clockGen (
        .clk (clk),
        .rst (rst)
    );

    memTop uut (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchAck  (fetchAck),
        .fetchWord (fetchWord),
        .dataReq   (dataReq),
        .dataAddr  (dataAddr),
        .dataKind  (dataKind),
        .dataLen   (dataLen),
        .dataWdata (dataWdata),
        .dataAck   (dataAck),
        .dataRword (dataRword)
    );

    memScoreboard sb (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchAck  (fetchAck),
        .fetchWord (fetchWord),
        .dataReq   (dataReq),
        .dataAddr  (dataAddr),
        .dataKind  (dataKind),
        .dataLen   (dataLen),
        .dataWdata (dataWdata),
        .dataAck   (dataAck),
        .dataRword (dataRword),
        .checks    (checks),
        .errors    (errors)
    );

    task automatic abortRun(input string reason);
        $display("timeout at %0t: %s within %0d cycles", $time, reason, ackTimeout);
        timedOut = 1'b1;
        // this client stops here until the run ends
        forever @(negedge clk);
    endtask

    // ends the run as soon as any client gives up waiting
    initial begin : timeoutWatch
        wait (timedOut);
        $display("Test failed");
        $finish;
    end

    // one full four-phase cycle with the payload left in place after req drops
    task automatic dataAccess(
        input logic [`MEM_ADDR_W-1:0] addr,
        input accessKindT             kind,
        input accessLenT              len,
        input logic [`MEM_WORD_W-1:0] wdata
    );
        int waited;
        @(negedge clk);
        dataAddr = addr;
        dataKind = kind;
        dataLen = len;
        dataWdata = wdata;
        dataReq = 1'b1;
        waited = 0;
        while (!dataAck && waited < ackTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!dataAck) begin
            abortRun("data ack did not rise");
        end
        dataReq = 1'b0;
        waited = 0;
        while (dataAck && waited < ackTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (dataAck) begin
            abortRun("data ack did not fall");
        end
    endtask

    task automatic fetchAccess(input logic [`MEM_ADDR_W-1:0] addr);
        int waited;
        @(negedge clk);
        fetchAddr = addr;
        fetchReq = 1'b1;
        waited = 0;
        while (!fetchAck && waited < ackTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!fetchAck) begin
            abortRun("fetch ack did not rise");
        end
        fetchReq = 1'b0;
        waited = 0;
        while (fetchAck && waited < ackTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (fetchAck) begin
            abortRun("fetch ack did not fall");
        end
    endtask

    // aligned addresses inside a 64-byte window so loads hit stored bytes
    task automatic randomData(input int count);
        logic [31:0]            r;
        logic [`MEM_ADDR_W-1:0] addr;
        accessKindT             kind;
        accessLenT              len;
        for (int n = 0; n < count; n++) begin
            r = $random(dataSeed);
            if (r % 3 == 0) begin
                len = len1;
            end else if (r % 3 == 1) begin
                len = len2;
            end else begin
                len = len4;
            end
            r = $random(dataSeed);
            if (r[0]) begin
                kind = accStore;
            end else begin
                kind = accLoad;
            end
            r = $random(dataSeed);
            addr = '0;
            addr[5:0] = r[5:0];
            if (len == len2) begin
                addr[0] = 1'b0;
            end
            if (len == len4) begin
                addr[1:0] = 2'b00;
            end
            r = $random(dataSeed);
            dataAccess(addr, kind, len, r);
        end
    endtask

    task automatic randomFetch(input int count);
        logic [31:0]            r;
        logic [`MEM_ADDR_W-1:0] addr;
        for (int n = 0; n < count; n++) begin
            r = $random(fetchSeed);
            addr = '0;
            addr[5:2] = r[3:0];
            fetchAccess(addr);
        end
    endtask

    task automatic endTest(input string name);
        int failsNow;
        failsNow = errors + uut.hsChk.failCount;
        if (failsNow == failsSeen) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, failsNow - failsSeen);
        end
        failsSeen = failsNow;
    endtask

    // stall is high about one cycle in four while enabled
    initial begin : stallDriver
        logic [31:0] r;
        stall = 1'b0;
        forever begin
            @(negedge clk);
            r = $random(stallSeed);
            stall = stallOn && (r[1:0] == 2'b00);
        end
    end

    initial begin : mainFlow
        int waited;
        stallOn = 1'b0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataAddr = '0;
        dataKind = accLoad;
        dataLen = len1;
        dataWdata = '0;
        waited = 0;
        @(negedge clk);
        while (rst && waited < ackTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (rst) begin
            abortRun("reset was not released");
        end

        repeat (8) @(negedge clk);
        fetchAccess(17'h00100);
        endTest("test 1 idle and unwritten fetch");

        dataAccess(17'h00010, accStore, len4, 32'h11223344);
        dataAccess(17'h00011, accStore, len1, 32'hdeadbeab);
        dataAccess(17'h00016, accStore, len2, 32'hcafebeef);
        dataAccess(17'h00018, accStore, len4, 32'h8899aabb);
        dataAccess(17'h0001b, accStore, len1, 32'h00000077);
        dataAccess(17'h00010, accLoad, len4, '0);
        dataAccess(17'h00014, accLoad, len4, '0);
        dataAccess(17'h00018, accLoad, len4, '0);
        endTest("test 2 store placement");

        dataAccess(17'h00011, accLoad, len1, '0);
        dataAccess(17'h00013, accLoad, len1, '0);
        dataAccess(17'h00016, accLoad, len2, '0);
        dataAccess(17'h0001a, accLoad, len2, '0);
        endTest("test 3 short loads");

        fork
            dataAccess(17'h00020, accStore, len4, 32'h0badf00d);
            fetchAccess(17'h00020);
        join
        fork
            fetchAccess(17'h00018);
            dataAccess(17'h00024, accLoad, len4, '0);
        join
        endTest("test 4 concurrent clients");

        stallOn = 1'b1;
        fork
            randomData(200);
            randomFetch(100);
        join
        stallOn = 1'b0;
        endTest("test 5 random traffic with stall");

        $display("checks=%0d errors=%0d assertion failures=%0d",
                 checks, errors, uut.hsChk.failCount);
        if (errors == 0 && uut.hsChk.failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* memScoreboard.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module memScoreboard
    import memAccessPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchReq,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    input  logic                   fetchAck,
    input  logic [`MEM_WORD_W-1:0] fetchWord,
    input  logic                   dataReq,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  accessKindT             dataKind,
    input  accessLenT              dataLen,
    input  logic [`MEM_WORD_W-1:0] dataWdata,
    input  logic                   dataAck,
    input  logic [`MEM_WORD_W-1:0] dataRword,
    output int                     checks,
    output int                     errors
);
    logic [7:0] model [`MEM_DEPTH];
    int         checkCount = 0;
    int         errorCount = 0;
    logic       fetchAckLast = 1'b0;
    logic       dataAckLast = 1'b0;
    logic       fetchReqLast = 1'b0;
    logic       dataReqLast = 1'b0;

    assign checks = checkCount;
    assign errors = errorCount;

    // little-endian gather, upper bytes stay zero
    function automatic logic [`MEM_WORD_W-1:0] modelWord(
        input logic [`MEM_ADDR_W-1:0] addr,
        input int                     nBytes
    );
        logic [`MEM_WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < nBytes; i++) begin
            w[8*i +: 8] = model[int'(addr) + i];
        end
        return w;
    endfunction

    task automatic compareWord(
        input string                  name,
        input logic [`MEM_WORD_W-1:0] expected,
        input logic [`MEM_WORD_W-1:0] actual
    );
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH time=%0t signal=%s expected=%08h actual=%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic dataAckRose();
        int nBytes;
        nBytes = (dataLen == len1) ? 1 : ((dataLen == len2) ? 2 : 4);
        if (dataKind == accStore) begin
            for (int i = 0; i < nBytes; i++) begin
                model[int'(dataAddr) + i] = dataWdata[8*i +: 8];
            end
        end else begin
            compareWord("dataRword", modelWord(dataAddr, nBytes), dataRword);
        end
    endtask

    // req is taken from the previous falling edge, the client may drop it now
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                model[i] = 8'h00;
            end
        end else begin
            if (dataAck && !dataAckLast) begin
                if (!dataReqLast) begin
                    errorCount++;
                    $display("data ack rose at %0t with no request pending", $time);
                end else begin
                    dataAckRose();
                end
            end
            if (fetchAck && !fetchAckLast) begin
                if (!fetchReqLast) begin
                    errorCount++;
                    $display("fetch ack rose at %0t with no request pending", $time);
                end else begin
                    compareWord("fetchWord", modelWord(fetchAddr, 4), fetchWord);
                end
            end
        end
        dataAckLast = dataAck;
        fetchAckLast = fetchAck;
        dataReqLast = dataReq;
        fetchReqLast = fetchReq;
    end

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod = 50,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release on a falling edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* memTop_chk.sv */
`timescale 1ns/1ps

module memTopChk (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic fetchReq,
    input logic fetchAck,
    input logic dataReq,
    input logic dataAck,
    input logic ramWe
);
    int failCount = 0;

    fetchAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(fetchAck) |-> $past(fetchReq))
        else begin
            $error("fetch ack rose without a request");
            failCount++;
        end

    dataAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(dataAck) |-> $past(dataReq))
        else begin
            $error("data ack rose without a request");
            failCount++;
        end

    // req may only drop once ack is up
    fetchReqHeld: assert property (@(posedge clk) disable iff (rst)
        $fell(fetchReq) |-> fetchAck)
        else begin
            $error("fetch req dropped before ack");
            failCount++;
        end

    dataReqHeld: assert property (@(posedge clk) disable iff (rst)
        $fell(dataReq) |-> dataAck)
        else begin
            $error("data req dropped before ack");
            failCount++;
        end

    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !ramWe)
        else begin
            $error("RAM write enable high during stall");
            failCount++;
        end

endmodule

bind memTop memTopChk hsChk (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .fetchReq (fetchReq),
    .fetchAck (fetchAck),
    .dataReq  (dataReq),
    .dataAck  (dataAck),
    .ramWe    (ramWe)
);

/* memTop.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module memTop
    import memAccessPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   fetchReq,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    output logic                   fetchAck,
    output logic [`MEM_WORD_W-1:0] fetchWord,
    input  logic                   dataReq,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  accessKindT             dataKind,
    input  accessLenT              dataLen,
    input  logic [`MEM_WORD_W-1:0] dataWdata,
    output logic                   dataAck,
    output logic [`MEM_WORD_W-1:0] dataRword
);
    dataReqT                dataPayload;
    fetchReqT               fetchHeld;
    dataReqT                dataHeld;
    logic                   fetchPending;
    logic                   dataPending;
    logic                   fetchDone;
    logic                   dataDone;
    logic [`MEM_WORD_W-1:0] seqResult;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic                   ramWe;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    assign dataPayload = '{addr: dataAddr, kind: dataKind, len: dataLen, wdata: dataWdata};

    reqCapture #(.payloadT(fetchReqT)) fetchCap (
        .clk     (clk),
        .rst     (rst),
        .req     (fetchReq),
        .payload (fetchAddr),
        .done    (fetchDone),
        .result  (seqResult),
        .ack     (fetchAck),
        .pending (fetchPending),
        .held    (fetchHeld),
        .word    (fetchWord)
    );

    reqCapture #(.payloadT(dataReqT)) dataCap (
        .clk     (clk),
        .rst     (rst),
        .req     (dataReq),
        .payload (dataPayload),
        .done    (dataDone),
        .result  (seqResult),
        .ack     (dataAck),
        .pending (dataPending),
        .held    (dataHeld),
        .word    (dataRword)
    );

    memSequencer seq (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .fetchPending (fetchPending),
        .fetchHeld    (fetchHeld),
        .dataPending  (dataPending),
        .dataHeld     (dataHeld),
        .ramRdata     (ramRdata),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .result       (seqResult),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata)
    );

    byteRam ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

/* byteRam.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module byteRam (
    input  logic                   clk,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  logic                   we,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);
    logic [7:0] mem [`MEM_DEPTH];

    // contents start cleared, no preload
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read before write on the same address
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* memSequencer.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module memSequencer
    import memAccessPkg::*;
    import memCtrlPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   fetchPending,
    input  fetchReqT               fetchHeld,
    input  logic                   dataPending,
    input  dataReqT                dataHeld,
    input  logic [7:0]             ramRdata,
    output logic                   fetchDone,
    output logic                   dataDone,
    output logic [`MEM_WORD_W-1:0] result,
    output logic [`MEM_ADDR_W-1:0] ramAddr,
    output logic                   ramWe,
    output logic [7:0]             ramWdata
);
    busOwnerT               owner;
    busOwnerT               curOwner;
    seqPhaseT               phase;
    seqPhaseT               lastIdx;
    logic                   lastPhase;
    logic                   isStore;
    logic [1:0]             byteIdx;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [`MEM_ADDR_W-1:0] phaseOff;
    logic [`MEM_WORD_W-1:0] gather;
    logic [`MEM_WORD_W-1:0] assembled;

    // a free bus is granted in the same cycle, data ahead of fetch
    always_comb begin
        if (owner != ownNone) begin
            curOwner = owner;
        end else if (dataPending) begin
            curOwner = ownData;
        end else if (fetchPending) begin
            curOwner = ownFetch;
        end else begin
            curOwner = ownNone;
        end
    end

    assign isStore  = (curOwner == ownData) && (dataHeld.kind == accStore);
    assign baseAddr = (curOwner == ownData) ? dataHeld.addr : fetchHeld;

    // loads need one extra phase for the read latency of the RAM
    always_comb begin
        case (curOwner)
            ownFetch: begin
                lastIdx = seqPhaseT'(`MEM_MAX_LEN);
            end
            ownData: begin
                if (dataHeld.kind == accStore) begin
                    lastIdx = lenBytes(dataHeld.len) - 3'd1;
                end else begin
                    lastIdx = lenBytes(dataHeld.len);
                end
            end
            default: begin
                lastIdx = '0;
            end
        endcase
    end

    assign lastPhase = (curOwner != ownNone) && (phase == lastIdx);
    assign fetchDone = !stall && lastPhase && (curOwner == ownFetch);
    assign dataDone  = !stall && lastPhase && (curOwner == ownData);

    // while stalled, re-issue the previous byte address so that
    // rdata still carries the byte the next phase expects
    assign phaseOff = {{(`MEM_ADDR_W-3){1'b0}}, phase}
                    - {{(`MEM_ADDR_W-1){1'b0}}, stall};
    assign ramAddr  = baseAddr + phaseOff;

    assign ramWe    = isStore && !stall;
    assign ramWdata = dataHeld.wdata[{phase[1:0], 3'b000} +: 8];

    // byte that arrives now was addressed one phase earlier
    assign byteIdx = phase[1:0] - 2'd1;

    always_comb begin
        assembled = gather;
        assembled[{byteIdx, 3'b000} +: 8] = ramRdata;
    end

    assign result = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
            phase <= '0;
        end else if (!stall && curOwner != ownNone) begin
            if (lastPhase) begin
                owner <= ownNone;
                phase <= '0;
            end else begin
                owner <= curOwner;
                phase <= phase + 3'd1;
            end
        end
    end

    // read bytes collect here, cleared as each access starts
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (phase == '0) begin
                gather <= '0;
            end else begin
                gather <= assembled;
            end
        end
    end

endmodule

/* reqCapture.sv */
`timescale 1ns/1ps
`include "memConsts.svh"

module reqCapture
    import memAccessPkg::*;
#(
    parameter type payloadT = fetchReqT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  payloadT                payload,
    input  logic                   done,
    input  logic [`MEM_WORD_W-1:0] result,
    output logic                   ack,
    output logic                   pending,
    output payloadT                held,
    output logic [`MEM_WORD_W-1:0] word
);
    logic idle;
    logic take;
    logic finish;

    // free to accept a new request only once the last ack has dropped
    assign idle   = !pending && !ack;
    assign take   = idle && req;
    assign finish = pending && done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b1;
        end else if (finish) begin
            pending <= 1'b0;
        end
    end

    // four-phase ack side
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (finish) begin
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    // payload held for the sequencer until the cycle completes
    always_ff @(posedge clk) begin
        if (take) begin
            held <= payload;
        end
    end

    // result stays valid for as long as ack is high
    always_ff @(posedge clk) begin
        if (finish) begin
            word <= result;
        end
    end

endmodule

/* memCtrlPkg.sv */
package memCtrlPkg;

    // who currently drives the RAM
    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } busOwnerT;

    // byte step of the running access, 0 to 4
    typedef logic [2:0] seqPhaseT;

endpackage

/* memAccessPkg.sv */
`include "memConsts.svh"

package memAccessPkg;

    typedef enum logic {
        accLoad,
        accStore
    } accessKindT;

    // byte count code of a data access
    typedef enum logic [1:0] {
        len1 = 2'd0,
        len2 = 2'd1,
        len4 = 2'd2
    } accessLenT;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        accessKindT             kind;
        accessLenT              len;
        logic [`MEM_WORD_W-1:0] wdata;
    } dataReqT;

    typedef logic [`MEM_ADDR_W-1:0] fetchReqT;

    function automatic logic [2:0] lenBytes(accessLenT len);
        case (len)
            len1:    return 3'd1;
            len2:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

/* memConsts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address into the RAM
`define MEM_ADDR_W 17

// instruction and data word
`define MEM_WORD_W 32

// RAM size in bytes
`define MEM_DEPTH (1 << `MEM_ADDR_W)

// longest access, also the byte count of a fetch
`define MEM_MAX_LEN 4

`endif
